/* compile.f */
+incdir+src
src/capture_pkg.sv
src/sample_fifo.sv
src/capture_fsm.sv
src/word_packer.sv
src/word_port.sv
src/error_monitor.sv
src/capture_top.sv
tb/tb_capture.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_capture
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "test run did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/tb_capture.sv */
`default_nettype none

`include "capture_settings.svh"

module tb_capture;
    timeunit 1ns;
    timeprecision 100ps;

    import capture_pkg::*;

    logic                    adc_sampleclk;
    logic                    reset;
    logic                    arm_i;
    logic                    trigger_i;
    logic                    clear_errors_i;
    sample_t                 adc_data_i;
    logic [`PRESAMPLE_W-1:0] presample_i;
    logic [`COUNT_W-1:0]     total_samples_i;
    word_t                   word_data_o;
    logic                    word_req_o;
    logic                    word_ack_i;
    logic                    capture_done_o;
    logic                    armed_o;
    error_stat_t             error_stat_o;
    error_stat_t             first_error_stat_o;
    logic                    error_flag_o;

    sample_t     sample_count;      // next counter value for adc_data_i
    logic        inject_clip;
    logic        ack_block;         // consumer stalls new transfers
    logic [1:0]  rsp_state;
    int          ack_delay;
    logic        arm_q;
    logic        trig_q;
    int          arm_cyc;
    int          trig_cyc;
    sample_t     hist [$];          // adc_data_i as seen at each clock edge
    word_t       got [$];
    word_t       exp_words [$];
    int          errors;
    int          checks;

    capture_top UUT (
        .adc_sampleclk      (adc_sampleclk),
        .reset              (reset),
        .arm_i              (arm_i),
        .trigger_i          (trigger_i),
        .clear_errors_i     (clear_errors_i),
        .adc_data_i         (adc_data_i),
        .presample_i        (presample_i),
        .total_samples_i    (total_samples_i),
        .word_data_o        (word_data_o),
        .word_req_o         (word_req_o),
        .word_ack_i         (word_ack_i),
        .capture_done_o     (capture_done_o),
        .armed_o            (armed_o),
        .error_stat_o       (error_stat_o),
        .first_error_stat_o (first_error_stat_o),
        .error_flag_o       (error_flag_o)
    );

    always #4 adc_sampleclk = ~adc_sampleclk;

    // adc counter, skips 0x000 and 0xfff so only the injected sample clips
    always @(posedge adc_sampleclk) begin
        sample_count <= (sample_count >= 12'hffe) ? 12'h001 : sample_count + 1'b1;
        adc_data_i   <= inject_clip ? 12'hfff : sample_count;
    end

    // record the samples and the cycles of the arm and trigger edges
    always @(posedge adc_sampleclk) begin
        if (arm_i && !arm_q)
            arm_cyc = hist.size();
        if (trigger_i && !trig_q)
            trig_cyc = hist.size();
        hist.push_back(adc_data_i);
        arm_q  <= arm_i;
        trig_q <= trigger_i;
    end

    // four-phase consumer, acks after 0 to 3 cycles
    always @(posedge adc_sampleclk) begin
        if (reset) begin
            word_ack_i <= 1'b0;
            rsp_state  <= 2'd0;
        end
        else begin
            case (rsp_state)
                2'd0: begin
                    if (word_req_o && !ack_block) begin
                        got.push_back(word_data_o);
                        ack_delay <= $urandom % 4;
                        rsp_state <= 2'd1;
                    end
                end
                2'd1: begin
                    if (ack_delay == 0) begin
                        word_ack_i <= 1'b1;
                        rsp_state  <= 2'd2;
                    end
                    else
                        ack_delay <= ack_delay - 1;
                end
                default: begin
                    if (!word_req_o) begin      // req dropped, close the transfer
                        word_ack_i <= 1'b0;
                        rsp_state  <= 2'd0;
                    end
                end
            endcase
        end
    end

    a_req_after_ack: assert property (@(posedge adc_sampleclk) disable iff (reset)
        $rose(word_req_o) |-> !word_ack_i)
    else begin
        errors++;
        $display("word_req_o rose while word_ack_i was still high");
    end

    a_data_held: assert property (@(posedge adc_sampleclk) disable iff (reset)
        word_req_o && $past(word_req_o) |-> $stable(word_data_o))
    else begin
        errors++;
        $display("word_data_o changed while word_req_o was high");
    end

    task automatic check_value(input string name, input logic [63:0] val,
                               input logic [63:0] exp);
        checks++;
        assert (val === exp) else begin
            errors++;
            $display("FAIL %s got %h exp %h", name, val, exp);
        end
    endtask

    // 16 samples, first in the msbs, make three words sent high word first
    task automatic build_expected(input int first, input int count);
        logic [3*`WORD_W-1:0] group;
        sample_t              smp;
        int                   padded;
        int                   n;
        exp_words.delete();
        group  = '0;
        padded = ((count + `PACK_PERIOD - 1) / `PACK_PERIOD) * `PACK_PERIOD;
        for (n = 0; n < padded; n++) begin
            smp   = (n < count) ? hist[first + n] : '0;     // zero filler
            group = {group[3*`WORD_W-`SAMPLE_W-1:0], smp};
            if (n % `PACK_PERIOD == `PACK_PERIOD - 1) begin
                exp_words.push_back(group[3*`WORD_W-1:2*`WORD_W]);
                exp_words.push_back(group[2*`WORD_W-1:`WORD_W]);
                exp_words.push_back(group[`WORD_W-1:0]);
            end
        end
    endtask

    task automatic compare_words();
        int i;
        checks++;
        assert (got.size() == exp_words.size()) else begin
            errors++;
            $display("wrong number of words: got %0d, expected %0d",
                     got.size(), exp_words.size());
        end
        for (i = 0; i < exp_words.size() && i < got.size(); i++)
            check_value($sformatf("word_data_o[%0d]", i), got[i], exp_words[i]);
    endtask

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        while (!capture_done_o && n < limit) begin
            @(posedge adc_sampleclk);
            n++;
        end
        checks++;
        assert (capture_done_o) else begin
            errors++;
            $display("timeout after %0d cycles waiting for capture_done_o", limit);
        end
    endtask

    // arm edge also clears the status and the done flag
    task automatic start_capture(input int presamples, input int total);
        got.delete();
        presample_i     <= `PRESAMPLE_W'(presamples);
        total_samples_i <= `COUNT_W'(total);
        arm_i           <= 1'b1;
        @(posedge adc_sampleclk);
        arm_i <= 1'b0;
        @(posedge adc_sampleclk);
        check_value("armed_o", armed_o, 1);
        check_value("capture_done_o", capture_done_o, 0);
        check_value("error_stat_o", error_stat_o, 0);
        check_value("error_flag_o", error_flag_o, 0);
    endtask

    task automatic fire_trigger(input int delay);
        repeat (delay) @(posedge adc_sampleclk);
        trigger_i <= 1'b1;
        repeat (2) @(posedge adc_sampleclk);
        trigger_i <= 1'b0;
    endtask

    task automatic run_capture(input int presamples, input int total, input int delay,
                               input bit early);
        int first;
        start_capture(presamples, total);
        fire_trigger(delay);
        wait_done(400);
        // an early trigger keeps every sample written since the arm edge
        first = early ? arm_cyc + 1 : trig_cyc - presamples;
        build_expected(first, total);
        compare_words();
        check_value("word_req_o", word_req_o, 0);
    endtask

    initial begin
        int          seed;
        error_stat_t exp_err;
        seed            = $urandom(66);
        adc_sampleclk   = 1'b0;
        reset           = 1'b1;
        arm_i           = 1'b0;
        trigger_i       = 1'b0;
        clear_errors_i  = 1'b0;
        adc_data_i      = 12'h001;
        presample_i     = '0;
        total_samples_i = '0;
        word_ack_i      = 1'b0;
        sample_count    = 12'h002;
        inject_clip     = 1'b0;
        ack_block       = 1'b0;
        arm_q           = 1'b0;
        trig_q          = 1'b0;
        arm_cyc         = 0;
        trig_cyc        = 0;
        errors          = 0;
        checks          = 0;

        repeat (4) @(posedge adc_sampleclk);
        reset <= 1'b0;
        repeat (2) @(posedge adc_sampleclk);
        check_value("word_req_o", word_req_o, 0);
        check_value("capture_done_o", capture_done_o, 0);
        check_value("armed_o", armed_o, 0);
        check_value("error_flag_o", error_flag_o, 0);

        run_capture(0, 32, 6, 1'b0);            // basic, six words
        check_value("error_flag_o", error_flag_o, 0);
        run_capture(5, 21, 12, 1'b0);           // presamples, padded to 32
        check_value("error_flag_o", error_flag_o, 0);
        run_capture(0, 20, 4, 1'b0);            // 12 zero filler samples
        check_value("error_flag_o", error_flag_o, 0);

        // trigger while the presamples are still filling
        run_capture(20, 32, 3, 1'b1);
        exp_err              = '0;
        exp_err[ERR_PRESAMP] = 1'b1;
        check_value("error_stat_o", error_stat_o, exp_err);
        check_value("first_error_stat_o", first_error_stat_o, exp_err);
        check_value("error_flag_o", error_flag_o, 1);

        // stalled consumer overflows the sample fifo, one clipped sample
        ack_block <= 1'b1;
        start_capture(0, 150);
        fire_trigger(2);
        inject_clip <= 1'b1;
        @(posedge adc_sampleclk);
        inject_clip <= 1'b0;
        repeat (`FIFO_DEPTH + 48) @(posedge adc_sampleclk);
        ack_block <= 1'b0;
        wait_done(1500);
        check_value("error_stat_o[ERR_FIFO_OVF]", error_stat_o[ERR_FIFO_OVF], 1);
        check_value("error_stat_o[ERR_CLIP]", error_stat_o[ERR_CLIP], 1);
        check_value("first_error_stat_o[ERR_CLIP]", first_error_stat_o[ERR_CLIP], 1);
        check_value("error_flag_o", error_flag_o, 1);

        clear_errors_i <= 1'b1;
        @(posedge adc_sampleclk);
        clear_errors_i <= 1'b0;
        @(posedge adc_sampleclk);
        check_value("error_stat_o", error_stat_o, 0);
        check_value("first_error_stat_o", first_error_stat_o, 0);
        check_value("error_flag_o", error_flag_o, 0);

        repeat (4) @(posedge adc_sampleclk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* src/capture_top.sv */
`default_nettype none

`include "capture_settings.svh"

module capture_top (
    input  wire                         adc_sampleclk,
    input  wire                         reset,
    input  wire                         arm_i,
    input  wire                         trigger_i,
    input  wire                         clear_errors_i,
    input  wire capture_pkg::sample_t   adc_data_i,
    input  wire [`PRESAMPLE_W-1:0]      presample_i,
    input  wire [`COUNT_W-1:0]          total_samples_i,
    output wire capture_pkg::word_t     word_data_o,
    output wire                         word_req_o,
    input  wire                         word_ack_i,
    output wire                         capture_done_o,
    output wire                         armed_o,
    output wire capture_pkg::error_stat_t error_stat_o,
    output wire capture_pkg::error_stat_t first_error_stat_o,
    output wire                         error_flag_o
);
    import capture_pkg::*;

    capture_state_e fsm_state;
    sample_t        fifo_dout;
    word_t          packed_word;
    logic           fifo_wr;
    logic           fifo_rd;
    logic           fifo_empty;
    logic           fifo_full;
    logic           fifo_ovf;
    logic           forward;
    logic           filler;
    logic           packed_valid;
    logic           buf_full;
    logic           port_empty;
    logic           word_ovf;
    logic           clip;
    logic           presamp_err;
    logic           arm_edge;
    logic           packer_idle;

    assign packer_idle = (fsm_state == ST_IDLE);

    capture_fsm U_fsm (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .arm_i           (arm_i),
        .trigger_i       (trigger_i),
        .presample_i     (presample_i),
        .total_samples_i (total_samples_i),
        .fifo_empty      (fifo_empty),
        .fifo_full       (fifo_full),
        .buf_full        (buf_full),
        .port_empty      (port_empty),
        .fifo_wr_o       (fifo_wr),
        .fifo_rd_o       (fifo_rd),
        .forward_o       (forward),
        .filler_o        (filler),
        .presamp_error_o (presamp_err),
        .state_o         (fsm_state),
        .armed_o         (armed_o),
        .capture_done_o  (capture_done_o),
        .arm_edge_o      (arm_edge)
    );

    sample_fifo U_fifo (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .wr_i          (fifo_wr),
        .rd_i          (fifo_rd),
        .data_i        (adc_data_i),
        .data_o        (fifo_dout),
        .empty_o       (fifo_empty),
        .full_o        (fifo_full),
        .overflow_o    (fifo_ovf)
    );

    word_packer U_packer (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .sample_i      (fifo_dout),
        .take_i        (forward),
        .filler_i      (filler),
        .idle_i        (packer_idle),
        .clip_o        (clip),
        .word_o        (packed_word),
        .word_valid_o  (packed_valid)
    );

    word_port U_port (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .word_i          (packed_word),
        .word_valid_i    (packed_valid),
        .buf_full_o      (buf_full),
        .word_data_o     (word_data_o),
        .word_req_o      (word_req_o),
        .word_ack_i      (word_ack_i),
        .empty_o         (port_empty),
        .word_overflow_o (word_ovf)
    );

    error_monitor U_errors (
        .adc_sampleclk      (adc_sampleclk),
        .reset              (reset),
        .clear_i            (clear_errors_i),
        .arm_edge_i         (arm_edge),
        .clip_i             (clip),
        .presamp_i          (presamp_err),
        .fifo_ovf_i         (fifo_ovf),
        .word_ovf_i         (word_ovf),
        .error_stat_o       (error_stat_o),
        .first_error_stat_o (first_error_stat_o),
        .error_flag_o       (error_flag_o)
    );

endmodule

`default_nettype wire

/* src/error_monitor.sv */
`default_nettype none

module error_monitor (
    input  wire                      adc_sampleclk,
    input  wire                      reset,
    input  wire                      clear_i,
    input  wire                      arm_edge_i,
    input  wire                      clip_i,
    input  wire                      presamp_i,
    input  wire                      fifo_ovf_i,
    input  wire                      word_ovf_i,
    output capture_pkg::error_stat_t error_stat_o,
    output capture_pkg::error_stat_t first_error_stat_o,
    output logic                     error_flag_o
);
    import capture_pkg::*;

    error_stat_t events;

    always_comb begin
        events               = '0;
        events[ERR_CLIP]     = clip_i;
        events[ERR_PRESAMP]  = presamp_i;
        events[ERR_FIFO_OVF] = fifo_ovf_i;
        events[ERR_WORD_OVF] = word_ovf_i;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset || clear_i || arm_edge_i) begin
            error_stat_o       <= '0;
            first_error_stat_o <= '0;
            error_flag_o       <= 1'b0;
        end
        else begin
            error_stat_o <= error_stat_o | events;     // sticky
            if ((events != '0) && !error_flag_o) begin
                first_error_stat_o <= events;          // all bits of the first bad cycle
                error_flag_o       <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/word_port.sv */
`default_nettype none

module word_port (
    input  wire                 adc_sampleclk,
    input  wire                 reset,
    input  wire capture_pkg::word_t word_i,
    input  wire                 word_valid_i,
    output logic                buf_full_o,
    output capture_pkg::word_t  word_data_o,
    output logic                word_req_o,
    input  wire                 word_ack_i,
    output logic                empty_o,
    output logic                word_overflow_o
);
    import capture_pkg::*;

    word_t      buf_q [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    assign buf_full_o      = (count == 2'd2);
    assign empty_o         = (count == 2'd0);
    assign push            = word_valid_i && !buf_full_o;
    assign pop             = word_req_o && word_ack_i;     // ack seen, head is done
    assign word_overflow_o = word_valid_i && buf_full_o;
    assign word_data_o     = buf_q[rd_ptr];

    always_ff @(posedge adc_sampleclk) begin
        if (push)
            buf_q[wr_ptr] <= word_i;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            wr_ptr     <= 1'b0;
            rd_ptr     <= 1'b0;
            count      <= 2'd0;
            word_req_o <= 1'b0;
        end
        else begin
            if (push)
                wr_ptr <= !wr_ptr;
            if (pop)
                rd_ptr <= !rd_ptr;
            count <= count + 2'(push) - 2'(pop);

            // four-phase: next req waits for ack to drop
            if (pop)
                word_req_o <= 1'b0;
            else if (!word_req_o && !word_ack_i && !empty_o)
                word_req_o <= 1'b1;
        end
    end

    a_data_stable: assert property (@(posedge adc_sampleclk) disable iff (reset)
        word_req_o && $past(word_req_o) |-> $stable(word_data_o));

endmodule

`default_nettype wire

/* src/word_packer.sv */
`default_nettype none

`include "capture_settings.svh"

module word_packer (
    input  wire                   adc_sampleclk,
    input  wire                   reset,
    input  wire capture_pkg::sample_t sample_i,
    input  wire                   take_i,
    input  wire                   filler_i,
    input  wire                   idle_i,
    output logic                  clip_o,
    output capture_pkg::word_t    word_o,
    output logic                  word_valid_o
);
    import capture_pkg::*;

    // word 0: 6 samples, 8 bits left over
    // word 1: 5 samples, 4 bits left over
    // word 2: 5 samples, none left over
    localparam int SHIFT_W = 6 * `SAMPLE_W;

    logic [SHIFT_W-1:0] shifter;
    logic [SHIFT_W-1:0] next_shift;
    logic [1:0]         phase;
    logic [2:0]         taken;          // samples taken into the current word
    logic               shift_en;
    logic               word_end;
    sample_t            din;

    assign shift_en   = take_i || filler_i;
    assign din        = filler_i ? '0 : sample_i;
    assign next_shift = {shifter[SHIFT_W-`SAMPLE_W-1:0], din};
    assign word_end   = (phase == 2'd0) ? (taken == 3'd5) : (taken == 3'd4);

    // adc rails, filler zeros do not count
    assign clip_o = take_i && !filler_i && ((sample_i == '1) || (sample_i == '0));

    always_ff @(posedge adc_sampleclk) begin
        if (shift_en)
            shifter <= next_shift;
        if (shift_en && word_end) begin
            case (phase)
                2'd0:    word_o <= next_shift[71:8];
                2'd1:    word_o <= next_shift[67:4];
                default: word_o <= next_shift[63:0];
            endcase
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset || idle_i) begin
            phase        <= 2'd0;
            taken        <= 3'd0;
            word_valid_o <= 1'b0;
        end
        else begin
            word_valid_o <= shift_en && word_end;
            if (shift_en) begin
                if (word_end) begin
                    taken <= 3'd0;
                    phase <= (phase == 2'd2) ? 2'd0 : phase + 1'b1;
                end
                else
                    taken <= taken + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/capture_fsm.sv */
`default_nettype none

`include "capture_settings.svh"

module capture_fsm (
    input  wire                    adc_sampleclk,
    input  wire                    reset,
    input  wire                    arm_i,
    input  wire                    trigger_i,
    input  wire [`PRESAMPLE_W-1:0] presample_i,
    input  wire [`COUNT_W-1:0]     total_samples_i,
    input  wire                    fifo_empty,
    input  wire                    fifo_full,
    input  wire                    buf_full,
    input  wire                    port_empty,
    output logic                   fifo_wr_o,
    output logic                   fifo_rd_o,
    output logic                   forward_o,
    output logic                   filler_o,
    output logic                   presamp_error_o,
    output capture_pkg::capture_state_e state_o,
    output logic                   armed_o,
    output logic                   capture_done_o,
    output logic                   arm_edge_o
);
    import capture_pkg::*;

    localparam int PACK_W = $clog2(`PACK_PERIOD);

    capture_state_e      state;
    logic                arm_r;
    logic                trig_r;
    logic                trig_edge;
    logic [`COUNT_W-1:0] kept_cnt;      // samples held or sent, presamples included
    logic [`COUNT_W-1:0] presample_m1;
    logic [`COUNT_W-1:0] total_m1;
    logic [PACK_W-1:0]   pack_cnt;      // packer position within the pack period
    logic                took_r;
    logic                discard;
    logic                last_wr;
    logic                drained;

    assign arm_edge_o      = arm_i && !arm_r && (state == ST_IDLE);
    assign trig_edge       = trigger_i && !trig_r;
    assign presample_m1    = `COUNT_W'(presample_i) - 1'b1;
    assign total_m1        = total_samples_i - 1'b1;
    assign presamp_error_o = trig_edge && (state == ST_PRESAMP_FILLING);
    assign state_o         = state;

    always_comb begin
        fifo_wr_o = 1'b0;
        discard   = 1'b0;
        case (state)
            ST_PRESAMP_FILLING: fifo_wr_o = 1'b1;
            ST_PRESAMP_FULL: begin
                // keep the fifo at presample_i entries, trigger sample is kept
                fifo_wr_o = (presample_i != '0) || trig_edge;
                discard   = (presample_i != '0) && !trig_edge;
            end
            ST_TRIGGERED:       fifo_wr_o = 1'b1;
            default:            ;
        endcase
    end

    // back-pressure from the word buffer stalls forwarding and filler
    assign forward_o = ((state == ST_TRIGGERED) || (state == ST_FLUSH)) &&
                       !fifo_empty && !buf_full;
    assign filler_o  = (state == ST_FLUSH) && fifo_empty && (pack_cnt != '0) && !buf_full;
    assign fifo_rd_o = discard || forward_o || filler_o;

    assign last_wr = fifo_wr_o && (kept_cnt == total_m1) &&
                     ((state == ST_TRIGGERED) || trig_edge);

    // last word has left the packer and the word buffer
    assign drained = fifo_empty && (pack_cnt == '0) && !fifo_rd_o && !took_r && port_empty;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state          <= ST_IDLE;
            arm_r          <= 1'b0;
            trig_r         <= 1'b0;
            kept_cnt       <= '0;
            pack_cnt       <= '0;
            took_r         <= 1'b0;
            armed_o        <= 1'b0;
            capture_done_o <= 1'b0;
        end
        else begin
            arm_r  <= arm_i;
            trig_r <= trigger_i;
            took_r <= fifo_rd_o;

            if (fifo_wr_o && !discard)
                kept_cnt <= kept_cnt + 1'b1;
            if (forward_o || filler_o)
                pack_cnt <= (pack_cnt == PACK_W'(`PACK_PERIOD - 1)) ? '0 : pack_cnt + 1'b1;

            case (state)
                ST_IDLE: begin
                    if (arm_edge_o) begin
                        kept_cnt       <= '0;
                        pack_cnt       <= '0;
                        armed_o        <= 1'b1;
                        capture_done_o <= 1'b0;
                        state <= (presample_i != '0) ? ST_PRESAMP_FILLING : ST_PRESAMP_FULL;
                    end
                end
                ST_PRESAMP_FILLING: begin
                    if (trig_edge)                      // early trigger, fewer presamples
                        state <= last_wr ? ST_FLUSH : ST_TRIGGERED;
                    else if (kept_cnt == presample_m1)
                        state <= ST_PRESAMP_FULL;
                end
                ST_PRESAMP_FULL: begin
                    if (trig_edge)
                        state <= last_wr ? ST_FLUSH : ST_TRIGGERED;
                end
                ST_TRIGGERED: begin
                    if (last_wr)
                        state <= ST_FLUSH;
                end
                ST_FLUSH: begin
                    if (drained)
                        state <= ST_DONE;
                end
                ST_DONE: begin
                    capture_done_o <= 1'b1;     // held until the next arm
                    armed_o        <= 1'b0;
                    state          <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // only filler reads may hit an empty fifo
    a_rd_empty_filler: assert property (@(posedge adc_sampleclk) disable iff (reset)
        fifo_rd_o && fifo_empty |-> filler_o);

endmodule

`default_nettype wire

/* src/sample_fifo.sv */
`default_nettype none

`include "capture_settings.svh"

module sample_fifo (
    input  wire                   adc_sampleclk,
    input  wire                   reset,
    input  wire                   wr_i,
    input  wire                   rd_i,
    input  wire capture_pkg::sample_t data_i,
    output capture_pkg::sample_t  data_o,
    output logic                  empty_o,
    output logic                  full_o,
    output logic                  overflow_o
);
    import capture_pkg::*;

    localparam int AW = $clog2(`FIFO_DEPTH);

    sample_t       mem [`FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_wr;
    logic          do_rd;

    assign empty_o    = (count == '0);
    assign full_o     = (count == `FIFO_DEPTH);
    assign do_wr      = wr_i && !full_o;
    assign do_rd      = rd_i && !empty_o;
    assign overflow_o = wr_i && full_o;     // write is dropped
    assign data_o     = mem[rd_ptr];        // first word fall-through

    always_ff @(posedge adc_sampleclk) begin
        if (do_wr)
            mem[wr_ptr] <= data_i;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;    // wraps, depth is a power of two
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/capture_pkg.sv */
`default_nettype none

`include "capture_settings.svh"

package capture_pkg;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PRESAMP_FILLING,     // writing, fifo below presample count
        ST_PRESAMP_FULL,        // write and discard, waiting for trigger
        ST_TRIGGERED,           // writing post-trigger samples and forwarding
        ST_FLUSH,               // writes stopped, drain fifo and pad with filler
        ST_DONE
    } capture_state_e;

    typedef logic [`SAMPLE_W-1:0] sample_t;
    typedef logic [`WORD_W-1:0]   word_t;
    typedef logic [3:0]           error_stat_t;

    // bit positions in error_stat_t
    localparam int ERR_CLIP     = 0;
    localparam int ERR_PRESAMP  = 1;
    localparam int ERR_FIFO_OVF = 2;
    localparam int ERR_WORD_OVF = 3;

endpackage

`default_nettype wire

/* src/capture_settings.svh */
`ifndef CAPTURE_SETTINGS_SVH
`define CAPTURE_SETTINGS_SVH

// adc sample and output word widths
`define SAMPLE_W     12
`define WORD_W       64

// sample fifo entries, must be a power of two
`define FIFO_DEPTH   64

// count widths
`define PRESAMPLE_W  6
`define COUNT_W      16

// 16 samples of 12 bits fill three 64-bit words exactly
`define PACK_PERIOD  16

`endif
